//--- source/game_pkg.sv
// Game memory definitions
`default_nettype none

package game_pkg;

    // SDRAM side
    typedef logic [21:0] sdram_addr_t;   // Word address
    typedef logic [15:0] sdram_data_t;

    // Loader and client side
    typedef logic [24:0] ioctl_addr_t;   // Byte address from the loader
    typedef logic [16:0] rom_addr_t;

    // SDRAM word offsets of each ROM region
    localparam sdram_addr_t GFX_OFFSET  = 22'h1_0000;
    localparam sdram_addr_t PCM_OFFSET  = 22'h5_0000;
    localparam sdram_addr_t MAIN_OFFSET = 22'h0;

    // Loader bytes from here on go to the PROMs
    localparam ioctl_addr_t PROM_START = 25'h14_0000;

    localparam int NSLOTS = 3;   // Graphics, PCM, main

    // Slot to arbiter
    typedef struct packed {
        logic        active;
        sdram_addr_t addr;
    } slot_req_t;

    // Arbiter to slot
    typedef struct packed {
        logic        load;   // One cycle, only to the served slot
        sdram_data_t data;
    } slot_fill_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DATA,
        DONE
    } arb_state_t;

endpackage

`default_nettype wire

//--- source/cen_gen.sv
// Clock enable generator
`default_nettype none

module cen_gen (
    input  logic clk,
    input  logic rst_n,
    output logic cen12,     // 12 MHz
    output logic pxl_cen,   // 6 MHz
    output logic cen3,      // 3 MHz
    output logic cen1p5     // 1.5 MHz
);

    logic [3:0] cnt;

    // Free running divider of the 24 MHz clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= 4'd0;
        end else begin
            cnt <= cnt + 4'd1;
        end
    end

    // Every enable fires when its low counter bits are all zero,
    // so the slower ones always coincide with the faster ones
    assign cen12   = cnt[0] == 1'b0;
    assign pxl_cen = cnt[1:0] == 2'd0;
    assign cen3    = cnt[2:0] == 3'd0;
    assign cen1p5  = cnt == 4'd0;   // All four high together here

endmodule

`default_nettype wire

//--- source/rom_dwnld.sv
// ROM download converter
`default_nettype none

module rom_dwnld (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  downloading,
    input  game_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]            ioctl_dout,
    input  logic                  ioctl_wr,
    input  logic                  sdram_ack,
    output game_pkg::sdram_addr_t prog_addr,
    output logic [7:0]            prog_data,
    output logic [1:0]            prog_mask,   // Active low lane select
    output logic                  prog_we,
    output logic                  prom_we
);

    import game_pkg::*;

    logic        byte_wr;
    logic        is_prom;
    ioctl_addr_t prom_offset;

    assign byte_wr     = downloading && ioctl_wr;
    assign is_prom     = ioctl_addr >= PROM_START;
    assign prom_offset = ioctl_addr - PROM_START;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= byte_wr && is_prom;   // Single cycle strobe
            // SDRAM write stays requested until the controller takes it
            if (byte_wr && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    // Byte, address and lane of the latest loader write
    always_ff @(posedge clk) begin
        if (byte_wr) begin
            prog_data <= ioctl_dout;
            if (is_prom) begin
                // PROMs count bytes from the start of their own area
                prog_addr <= prom_offset[21:0];
                prog_mask <= 2'b11;
            end else begin
                prog_addr <= ioctl_addr[22:1];   // Byte to word address
                prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rom_slot.sv
// Cached ROM client slot
`default_nettype none

module rom_slot #(
    parameter int                    DW     = 8,    // 8 or 16
    parameter game_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cs,
    input  game_pkg::rom_addr_t  addr,   // Held by the client until ok
    input  game_pkg::slot_fill_t fill,
    output game_pkg::slot_req_t  req,
    output logic                 ok,
    output logic [DW-1:0]        dout
);

    import game_pkg::*;

    sdram_addr_t word_addr;
    sdram_addr_t cached_addr;
    sdram_data_t cached_data;
    sdram_data_t word;
    logic        valid;
    logic        hit;

    if (DW == 16) begin : g_word
        assign word_addr = OFFSET + sdram_addr_t'(addr);

        always_ff @(posedge clk) begin
            dout <= word;
        end
    end else begin : g_byte
        // Two client bytes per SDRAM word
        assign word_addr = OFFSET + sdram_addr_t'(addr[16:1]);

        always_ff @(posedge clk) begin
            dout <= addr[0] ? word[15:8] : word[7:0];   // Odd byte in upper lane
        end
    end

    assign hit  = valid && (cached_addr == word_addr);
    assign word = fill.load ? fill.data : cached_data;   // Fresh word bypasses cache

    // Request drops once the filled word shows up as a hit
    assign req = '{active: cs && !hit, addr: word_addr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            ok <= cs && (hit || fill.load);
            if (fill.load) begin
                valid <= 1'b1;
            end
        end
    end

    // One word cache
    always_ff @(posedge clk) begin
        if (fill.load) begin
            cached_addr <= word_addr;
            cached_data <= fill.data;
        end
    end

endmodule

`default_nettype wire

//--- source/rom_arbiter.sv
// SDRAM read arbiter for ROM slots
`default_nettype none

module rom_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  downloading,
    input  game_pkg::slot_req_t   slot_reqs  [game_pkg::NSLOTS],
    output game_pkg::slot_fill_t  slot_fills [game_pkg::NSLOTS],
    output logic                  sdram_req,
    output game_pkg::sdram_addr_t sdram_addr,
    input  logic                  sdram_ack,
    input  logic                  data_dst,
    input  logic                  data_rdy,
    input  game_pkg::sdram_data_t data_read
);

    import game_pkg::*;

    typedef logic [$clog2(NSLOTS)-1:0] slot_idx_t;

    arb_state_t  state;
    slot_idx_t   pick;
    slot_idx_t   grant;
    logic        any_active;
    logic        start;
    sdram_data_t data_buf;

    // Lowest index wins, so graphics first and main last
    always_comb begin
        pick       = '0;
        any_active = 1'b0;
        for (int i = NSLOTS - 1; i >= 0; i--) begin
            if (slot_reqs[i].active) begin
                pick       = slot_idx_t'(i);
                any_active = 1'b1;
            end
        end
    end

    assign start = (state == IDLE) && any_active && !downloading;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            grant     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        grant     <= pick;
                        sdram_req <= 1'b1;
                        state     <= REQ;
                    end
                end
                REQ: begin
                    if (sdram_ack) begin   // Request level held until here
                        sdram_req <= 1'b0;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= DONE;
                    end
                end
                DONE:    state <= IDLE;   // Load pulse goes out in this state
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sdram_addr <= slot_reqs[pick].addr;
        end
        if (state == WAIT_DATA && data_dst) begin
            data_buf <= data_read;
        end
    end

    always_comb begin
        for (int i = 0; i < NSLOTS; i++) begin
            slot_fills[i].load = (state == DONE) && (grant == slot_idx_t'(i));
            slot_fills[i].data = data_buf;
        end
    end

endmodule

`default_nettype wire

//--- source/game_top.sv
// Arcade game memory top
`default_nettype none

module game_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // Clock enables
    output logic                  cen12,
    output logic                  pxl_cen,
    output logic                  cen3,
    output logic                  cen1p5,
    // ROM download
    input  logic                  downloading,
    input  game_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]            ioctl_dout,
    input  logic                  ioctl_wr,
    output game_pkg::sdram_addr_t prog_addr,
    output logic [7:0]            prog_data,
    output logic [1:0]            prog_mask,   // Active low
    output logic                  prog_we,
    output logic                  prom_we,
    // SDRAM
    output logic                  sdram_req,
    output game_pkg::sdram_addr_t sdram_addr,
    input  logic                  sdram_ack,
    input  logic                  data_dst,
    input  logic                  data_rdy,
    input  game_pkg::sdram_data_t data_read,
    // Graphics ROM
    input  logic                  gfx_cs,
    input  game_pkg::rom_addr_t   gfx_addr,
    output logic                  gfx_ok,
    output logic [15:0]           gfx_data,
    // PCM ROM
    input  logic                  pcm_cs,
    input  game_pkg::rom_addr_t   pcm_addr,
    output logic                  pcm_ok,
    output logic [7:0]            pcm_data,
    // Main CPU ROM
    input  logic                  main_cs,
    input  game_pkg::rom_addr_t   main_addr,
    output logic                  main_ok,
    output logic [7:0]            main_data
);

    import game_pkg::*;

    slot_req_t  slot_reqs  [NSLOTS];
    slot_fill_t slot_fills [NSLOTS];

    cen_gen u_cen (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .cen12   ( cen12   ),
        .pxl_cen ( pxl_cen ),
        .cen3    ( cen3    ),
        .cen1p5  ( cen1p5  )
    );

    rom_dwnld u_dwnld (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    // Slot 0 has top priority
    rom_slot #(.DW(16), .OFFSET(GFX_OFFSET)) u_gfx (
        .clk   ( clk           ),
        .rst_n ( rst_n         ),
        .cs    ( gfx_cs        ),
        .addr  ( gfx_addr      ),
        .fill  ( slot_fills[0] ),
        .req   ( slot_reqs[0]  ),
        .ok    ( gfx_ok        ),
        .dout  ( gfx_data      )
    );

    rom_slot #(.DW(8), .OFFSET(PCM_OFFSET)) u_pcm (
        .clk   ( clk           ),
        .rst_n ( rst_n         ),
        .cs    ( pcm_cs        ),
        .addr  ( pcm_addr      ),
        .fill  ( slot_fills[1] ),
        .req   ( slot_reqs[1]  ),
        .ok    ( pcm_ok        ),
        .dout  ( pcm_data      )
    );

    rom_slot #(.DW(8), .OFFSET(MAIN_OFFSET)) u_main (
        .clk   ( clk           ),
        .rst_n ( rst_n         ),
        .cs    ( main_cs       ),
        .addr  ( main_addr     ),
        .fill  ( slot_fills[2] ),
        .req   ( slot_reqs[2]  ),
        .ok    ( main_ok       ),
        .dout  ( main_data     )
    );

    rom_arbiter u_arb (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),   // SDRAM belongs to the loader meanwhile
        .slot_reqs   ( slot_reqs   ),
        .slot_fills  ( slot_fills  ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

endmodule

`default_nettype wire

//--- testbench/sdram_model.sv
// Behavioral SDRAM model
`default_nettype none

module sdram_model (
    input  logic                  clk,
    input  logic                  prog_we,
    input  game_pkg::sdram_addr_t prog_addr,
    input  logic [7:0]            prog_data,
    input  logic [1:0]            prog_mask,   // Active low
    input  logic                  sdram_req,
    input  game_pkg::sdram_addr_t sdram_addr,
    output logic                  sdram_ack,
    output logic                  data_dst,
    output logic                  data_rdy,
    output game_pkg::sdram_data_t data_read
);

    import game_pkg::*;

    sdram_data_t mem [sdram_addr_t];   // Sparse word storage

    // Unwritten words read back a pattern of their whole address
    function automatic sdram_data_t read_word(sdram_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ {a[21:16], 10'h2a5};
    endfunction

    initial begin
        sdram_data_t word;
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (prog_we) begin
                word = read_word(prog_addr);
                if (!prog_mask[0]) begin
                    word[7:0] = prog_data;
                end
                if (!prog_mask[1]) begin
                    word[15:8] = prog_data;
                end
                mem[prog_addr] = word;
                @(posedge clk);
                sdram_ack <= 1'b1;   // Write taken
                @(posedge clk);
                sdram_ack <= 1'b0;
            end else if (sdram_req) begin
                @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                // Fixed read latency
                repeat (2) @(posedge clk);
                data_read <= read_word(sdram_addr);
                data_dst  <= 1'b1;
                data_rdy  <= 1'b1;
                @(posedge clk);
                data_dst  <= 1'b0;
                data_rdy  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/game_top_tb.sv
// Game memory testbench
`default_nettype none

module game_top_tb;

    import game_pkg::*;

    localparam int TIMEOUT = 200;   // Cycles per wait
    localparam int NREC    = 64;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cen12, pxl_cen, cen3, cen1p5;
    logic        downloading;
    ioctl_addr_t ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    sdram_addr_t prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we, prom_we;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_ack, data_dst, data_rdy;
    sdram_data_t data_read;
    logic        gfx_cs, pcm_cs, main_cs;
    rom_addr_t   gfx_addr, pcm_addr, main_addr;
    logic        gfx_ok, pcm_ok, main_ok;
    logic [15:0] gfx_data;
    logic [7:0]  pcm_data, main_data;

    logic [51:0] stim [NREC];   // Kind, slot, address, data

    always #20 clk = ~clk;

    game_top UUT (.*);

    sdram_model u_sdram (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Simulation stopped at %0t", $time);
    endtask

    task automatic check_addr(input string name, input sdram_addr_t got, input sdram_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input sdram_data_t got, input sdram_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // One cycle of a bounded wait
    task automatic tick(inout int cnt, input string what);
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT) begin
            fail_run({"Timed out waiting for ", what});
        end
    endtask

    // Offset plus word index, bytes paired into words on 8-bit slots
    function automatic sdram_addr_t word_addr_of(int slot, rom_addr_t a);
        case (slot)
            0:       return GFX_OFFSET + sdram_addr_t'(a);
            1:       return PCM_OFFSET + sdram_addr_t'(a / 2);
            default: return MAIN_OFFSET + sdram_addr_t'(a / 2);
        endcase
    endfunction

    function automatic logic ok_of(int slot);
        case (slot)
            0:       return gfx_ok;
            1:       return pcm_ok;
            default: return main_ok;
        endcase
    endfunction

    task automatic set_slot(input int slot, input logic cs, input rom_addr_t a);
        case (slot)
            0: begin
                gfx_cs   = cs;
                gfx_addr = a;
            end
            1: begin
                pcm_cs   = cs;
                pcm_addr = a;
            end
            default: begin
                main_cs   = cs;
                main_addr = a;
            end
        endcase
    endtask

    task automatic check_slot(input int slot, input sdram_data_t exp);
        case (slot)
            0: begin
                check_bit("gfx_ok", gfx_ok, 1'b1);
                check_data("gfx_data", gfx_data, exp);
            end
            1: begin
                check_bit("pcm_ok", pcm_ok, 1'b1);
                check_byte("pcm_data", pcm_data, exp[7:0]);
            end
            default: begin
                check_bit("main_ok", main_ok, 1'b1);
                check_byte("main_data", main_data, exp[7:0]);
            end
        endcase
    endtask

    task automatic download_byte(input ioctl_addr_t a, input logic [7:0] d);
        int cnt;
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (a < PROM_START) begin
            check_bit("prog_we", prog_we, 1'b1);
            check_bit("prom_we", prom_we, 1'b0);
            check_addr("prog_addr", prog_addr, sdram_addr_t'(a >> 1));
            check_byte("prog_data", prog_data, d);
            check_bit("prog_mask[0]", prog_mask[0], a[0]);   // Odd byte keeps low lane off
            check_bit("prog_mask[1]", prog_mask[1], !a[0]);
            cnt = 0;
            while (prog_we) begin
                tick(cnt, "prog_we to fall");
            end
        end else begin
            check_bit("prom_we", prom_we, 1'b1);
            check_bit("prog_we", prog_we, 1'b0);
            @(negedge clk);
            check_bit("prom_we", prom_we, 1'b0);   // Single pulse
            check_bit("prog_we", prog_we, 1'b0);
        end
    endtask

    task automatic read_single(input int slot, input rom_addr_t a, input sdram_data_t exp);
        int cnt;
        set_slot(slot, 1'b1, a);
        cnt = 0;
        while (!sdram_req) begin
            tick(cnt, "sdram_req");
        end
        check_addr("sdram_addr", sdram_addr, word_addr_of(slot, a));
        cnt = 0;
        while (!ok_of(slot)) begin
            tick(cnt, "slot ok");
        end
        check_slot(slot, exp);
        set_slot(slot, 1'b0, a);
        @(negedge clk);
    endtask

    // Cached word comes back without touching the SDRAM
    task automatic read_repeat(input int slot, input rom_addr_t a, input sdram_data_t exp);
        set_slot(slot, 1'b1, a);
        @(negedge clk);
        check_bit("sdram_req", sdram_req, 1'b0);
        check_slot(slot, exp);
        set_slot(slot, 1'b0, a);
        @(negedge clk);
    endtask

    initial begin
        int          idx;
        int          cnt;
        int          n;
        int          gs [3];
        rom_addr_t   ga [3];
        sdram_data_t ge [3];
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        gfx_cs      = 1'b0;
        pcm_cs      = 1'b0;
        main_cs     = 1'b0;
        gfx_addr    = '0;
        pcm_addr    = '0;
        main_addr   = '0;
        $readmemh("testbench/game_stim.txt", stim);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Enable cadence against a reference cycle count
        for (int k = 0; k < 64; k++) begin
            check_bit("cen12", cen12, logic'((k % 2) == 0));
            check_bit("pxl_cen", pxl_cen, logic'((k % 4) == 0));
            check_bit("cen3", cen3, logic'((k % 8) == 0));
            check_bit("cen1p5", cen1p5, logic'((k % 16) == 0));
            @(negedge clk);
        end

        idx         = 0;
        downloading = 1'b1;
        while (idx < NREC && stim[idx][51:48] == 4'h1) begin
            download_byte(stim[idx][40:16], stim[idx][7:0]);
            idx++;
        end
        @(negedge clk);
        downloading = 1'b0;

        while (idx < NREC && stim[idx][51:48] != 4'h0) begin
            case (stim[idx][51:48])
                4'h2: begin
                    read_single(int'(stim[idx][47:44]), stim[idx][32:16], stim[idx][15:0]);
                    idx++;
                end
                4'h3: begin
                    n = 0;
                    while (n < 3 && idx < NREC && stim[idx][51:48] == 4'h3) begin
                        gs[n] = int'(stim[idx][47:44]);
                        ga[n] = stim[idx][32:16];
                        ge[n] = stim[idx][15:0];
                        set_slot(gs[n], 1'b1, ga[n]);   // All raised in one cycle
                        n++;
                        idx++;
                    end
                    for (int i = 0; i < n; i++) begin
                        cnt = 0;
                        while (!sdram_req) begin
                            tick(cnt, "sdram_req");
                        end
                        check_addr("sdram_addr", sdram_addr, word_addr_of(gs[i], ga[i]));
                        cnt = 0;
                        while (sdram_req) begin
                            tick(cnt, "sdram_req to fall");
                        end
                    end
                    for (int i = 0; i < n; i++) begin
                        cnt = 0;
                        while (!ok_of(gs[i])) begin
                            tick(cnt, "slot ok");
                        end
                        check_slot(gs[i], ge[i]);
                    end
                    for (int i = 0; i < n; i++) begin
                        set_slot(gs[i], 1'b0, ga[i]);
                    end
                    @(negedge clk);
                end
                4'h4: begin
                    read_repeat(int'(stim[idx][47:44]), stim[idx][32:16], stim[idx][15:0]);
                    idx++;
                end
                default: fail_run($sformatf("Unknown record kind in stimulus line %0d", idx));
            endcase
        end

        // Records must run up to the end marker
        if (idx == 0 || idx >= NREC || stim[idx][51:48] !== 4'h0) begin
            fail_run("Stimulus records did not end with a valid end record");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
source/game_pkg.sv
source/cen_gen.sv
source/rom_dwnld.sv
source/rom_slot.sv
source/rom_arbiter.sv
source/game_top.sv
testbench/sdram_model.sv
testbench/game_top_tb.sv

//--- Makefile
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vgame_top_tb: vlog.f $(SRCS)
	verilator --binary --timing -f vlog.f --top-module game_top_tb -o Vgame_top_tb

run: obj_dir/Vgame_top_tb
	obj_dir/Vgame_top_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/game_stim.txt
// Each word: kind(1) slot(1) address(7) data(4) in hex
// Kind 1 download byte, 2 single read, 3 same-cycle read, 4 cached repeat, 0 end
1000000000011
1000000010022
1000000020033
1000000030044
10002000000A5
100020001005A
10002000200C3
100020003003C
1000A00000081
1000A0001007E
1000A00020096
1000A00030069
10014000000F0
100140001000F
2000000005AA5
210000001007E
2200000020033
3000000013CC3
3100000020096
3200000010022
4000000013CC3
4100000020096
4200000010022
0000000000000
